// ==== dual_issue_cfg.svh ====
`ifndef DUAL_ISSUE_CFG_SVH
`define DUAL_ISSUE_CFG_SVH

// ##########################################################################
// Core dimensions.
// ##########################################################################

// Integer datapath width.
`define DI_XLEN 32

// Architectural integer registers, x0 hardwired to zero.
`define DI_REG_COUNT 32

// Bits needed to name one register.
`define DI_REG_ADDR_W 5

`endif

// ==== dual_issue_pkg.sv ====
`include "dual_issue_cfg.svh"

package dual_issue_pkg;

    typedef logic [`DI_XLEN-1:0] word_t;
    typedef logic [`DI_REG_ADDR_W-1:0] reg_addr_t;

    // Shifts take src2[4:0]; LUI passes src2 through.
    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_AND  = 4'd2,
        ALU_OR   = 4'd3,
        ALU_XOR  = 4'd4,
        ALU_SLL  = 4'd5,
        ALU_SRL  = 4'd6,
        ALU_SRA  = 4'd7,
        ALU_SLT  = 4'd8,
        ALU_SLTU = 4'd9,
        ALU_LUI  = 4'd10
    } alu_op_t;

    // One decoded operation as issued.
    typedef struct packed {
        logic      valid;
        word_t     pc;
        alu_op_t   op;
        reg_addr_t src1;
        reg_addr_t src2;
        logic      src2_is_imm;
        word_t     imm;
        reg_addr_t dest;
    } issue_op_t;

    // Operation with its operands resolved.
    typedef struct packed {
        logic      wen;
        word_t     pc;
        alu_op_t   op;
        word_t     opnd1;
        word_t     opnd2;
        reg_addr_t dest;
    } exec_op_t;

    typedef struct packed {
        logic      wen;
        word_t     pc;
        reg_addr_t dest;
        word_t     value;
    } result_t;

    typedef struct packed {
        logic      wen;
        word_t     pc;
        reg_addr_t wnum;
        word_t     wdata;
    } trace_t;

endpackage

// ==== regfile.sv ====
`timescale 1ns/1ps

`include "dual_issue_cfg.svh"

module regfile (
    input  logic                            clk,
    input  logic                            reset,
    input  dual_issue_pkg::reg_addr_t [3:0] i_raddr,
    output dual_issue_pkg::word_t     [3:0] o_rdata,
    input  dual_issue_pkg::result_t         i_wr_a,
    input  dual_issue_pkg::result_t         i_wr_b
);
    import dual_issue_pkg::*;

    word_t regs [`DI_REG_COUNT];

    // ##########################################################################
    // Read ports.
    // ##########################################################################

    always_comb begin
        for (int i = 0; i < 4; i++) begin
            o_rdata[i] = regs[i_raddr[i]];
        end
    end

    // ##########################################################################
    // Write ports.
    // ##########################################################################

    // Port b is applied last so the younger lane wins on a collision.
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `DI_REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else begin
            if (i_wr_a.wen) begin
                regs[i_wr_a.dest] <= i_wr_a.value;
            end
            if (i_wr_b.wen) begin
                regs[i_wr_b.dest] <= i_wr_b.value;
            end
        end
    end

endmodule

// ==== operand_read.sv ====
`timescale 1ns/1ps

module operand_read (
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            i_issue,
    input  dual_issue_pkg::issue_op_t       i_issue_a,
    input  dual_issue_pkg::issue_op_t       i_issue_b,
    input  dual_issue_pkg::result_t         i_ex_result_a,
    input  dual_issue_pkg::result_t         i_ex_result_b,
    input  dual_issue_pkg::result_t         i_wb_result_a,
    input  dual_issue_pkg::result_t         i_wb_result_b,
    output dual_issue_pkg::reg_addr_t [3:0] o_raddr,
    input  dual_issue_pkg::word_t     [3:0] i_rdata,
    output dual_issue_pkg::exec_op_t        o_exec_a,
    output dual_issue_pkg::exec_op_t        o_exec_b
);
    import dual_issue_pkg::*;

    issue_op_t iss_a;
    issue_op_t iss_b;

    // Issue register; a low strobe turns both lanes into bubbles.
    always_ff @(posedge clk) begin
        if (reset) begin
            iss_a.valid <= 1'b0;
            iss_b.valid <= 1'b0;
        end else begin
            iss_a       <= i_issue_a;
            iss_b       <= i_issue_b;
            iss_a.valid <= i_issue && i_issue_a.valid;
            iss_b.valid <= i_issue && i_issue_b.valid;
        end
    end

    assign o_raddr[0] = iss_a.src1;
    assign o_raddr[1] = iss_a.src2;
    assign o_raddr[2] = iss_b.src1;
    assign o_raddr[3] = iss_b.src2;

    // ##########################################################################
    // Forwarding, youngest producer first.
    // ##########################################################################

    function automatic word_t select_operand(input reg_addr_t src, input word_t rf_data);
        word_t value;
        if (i_ex_result_b.wen && i_ex_result_b.dest == src) begin
            value = i_ex_result_b.value;
        end else if (i_ex_result_a.wen && i_ex_result_a.dest == src) begin
            value = i_ex_result_a.value;
        end else if (i_wb_result_b.wen && i_wb_result_b.dest == src) begin
            value = i_wb_result_b.value;
        end else if (i_wb_result_a.wen && i_wb_result_a.dest == src) begin
            value = i_wb_result_a.value;
        end else begin
            value = rf_data;
        end
        return value;
    endfunction

    always_comb begin
        // x0 writes are dropped here for the whole pipeline.
        o_exec_a.wen   = iss_a.valid && (iss_a.dest != '0);
        o_exec_a.pc    = iss_a.pc;
        o_exec_a.op    = iss_a.op;
        o_exec_a.opnd1 = select_operand(iss_a.src1, i_rdata[0]);
        o_exec_a.opnd2 = iss_a.src2_is_imm ? iss_a.imm
                                           : select_operand(iss_a.src2, i_rdata[1]);
        o_exec_a.dest  = iss_a.dest;

        o_exec_b.wen   = iss_b.valid && (iss_b.dest != '0);
        o_exec_b.pc    = iss_b.pc;
        o_exec_b.op    = iss_b.op;
        o_exec_b.opnd1 = select_operand(iss_b.src1, i_rdata[2]);
        o_exec_b.opnd2 = iss_b.src2_is_imm ? iss_b.imm
                                           : select_operand(iss_b.src2, i_rdata[3]);
        o_exec_b.dest  = iss_b.dest;
    end

    // Lane b may not consume lane a's result from the same pair.
    a_no_pair_dep: assert property (
        @(posedge clk) disable iff (reset)
        (o_exec_a.wen && iss_b.valid) |->
            (iss_b.src1 != iss_a.dest) && (iss_b.src2_is_imm || iss_b.src2 != iss_a.dest)
    ) else $error("lane b reads lane a dest x%0d in the same pair", iss_a.dest);

endmodule

// ==== alu_execute.sv ====
`timescale 1ns/1ps

module alu_execute (
    input  logic                     clk,
    input  logic                     reset,
    input  dual_issue_pkg::exec_op_t i_exec_a,
    input  dual_issue_pkg::exec_op_t i_exec_b,
    output dual_issue_pkg::result_t  o_result_a,
    output dual_issue_pkg::result_t  o_result_b
);
    import dual_issue_pkg::*;

    exec_op_t ex_a;
    exec_op_t ex_b;

    always_ff @(posedge clk) begin
        if (reset) begin
            ex_a.wen <= 1'b0;
            ex_b.wen <= 1'b0;
        end else begin
            ex_a <= i_exec_a;
            ex_b <= i_exec_b;
        end
    end

    // ##########################################################################
    // Lane ALUs.
    // ##########################################################################

    function automatic word_t alu(input alu_op_t op, input word_t a, input word_t b);
        word_t res;
        case (op)
            ALU_ADD:  res = a + b;
            ALU_SUB:  res = a - b;
            ALU_AND:  res = a & b;
            ALU_OR:   res = a | b;
            ALU_XOR:  res = a ^ b;
            ALU_SLL:  res = a << b[4:0];
            ALU_SRL:  res = a >> b[4:0];
            ALU_SRA:  res = $signed(a) >>> b[4:0];
            ALU_SLT:  res = word_t'($signed(a) < $signed(b));
            ALU_SLTU: res = word_t'(a < b);
            ALU_LUI:  res = b;
            default:  res = '0;
        endcase
        return res;
    endfunction

    function automatic logic op_legal(input alu_op_t op);
        return op inside {ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLL,
                          ALU_SRL, ALU_SRA, ALU_SLT, ALU_SLTU, ALU_LUI};
    endfunction

    always_comb begin
        o_result_a.wen   = ex_a.wen;
        o_result_a.pc    = ex_a.pc;
        o_result_a.dest  = ex_a.dest;
        o_result_a.value = alu(ex_a.op, ex_a.opnd1, ex_a.opnd2);

        o_result_b.wen   = ex_b.wen;
        o_result_b.pc    = ex_b.pc;
        o_result_b.dest  = ex_b.dest;
        o_result_b.value = alu(ex_b.op, ex_b.opnd1, ex_b.opnd2);
    end

    // An undefined op code from issue would otherwise retire as zero.
    a_op_legal_a: assert property (
        @(posedge clk) disable iff (reset) ex_a.wen |-> op_legal(ex_a.op)
    ) else $error("lane a illegal ALU op %0d", ex_a.op);

    a_op_legal_b: assert property (
        @(posedge clk) disable iff (reset) ex_b.wen |-> op_legal(ex_b.op)
    ) else $error("lane b illegal ALU op %0d", ex_b.op);

endmodule

// ==== writeback.sv ====
`timescale 1ns/1ps

module writeback (
    input  logic                    clk,
    input  logic                    reset,
    input  dual_issue_pkg::result_t i_result_a,
    input  dual_issue_pkg::result_t i_result_b,
    output dual_issue_pkg::result_t o_wb_result_a,
    output dual_issue_pkg::result_t o_wb_result_b,
    output dual_issue_pkg::trace_t  o_trace_a,
    output dual_issue_pkg::trace_t  o_trace_b
);
    import dual_issue_pkg::*;

    result_t wb_a;
    result_t wb_b;

    always_ff @(posedge clk) begin
        if (reset) begin
            wb_a.wen <= 1'b0;
            wb_b.wen <= 1'b0;
        end else begin
            wb_a <= i_result_a;
            wb_b <= i_result_b;
        end
    end

    // Same contents go to the rf write ports and to forwarding.
    assign o_wb_result_a = wb_a;
    assign o_wb_result_b = wb_b;

    // Trace lands on the edge that commits to the register file.
    always_ff @(posedge clk) begin
        if (reset) begin
            o_trace_a.wen <= 1'b0;
            o_trace_b.wen <= 1'b0;
        end else begin
            o_trace_a <= '{wen: wb_a.wen, pc: wb_a.pc, wnum: wb_a.dest, wdata: wb_a.value};
            o_trace_b <= '{wen: wb_b.wen, pc: wb_b.pc, wnum: wb_b.dest, wdata: wb_b.value};
        end
    end

    a_trace_a_no_x0: assert property (
        @(posedge clk) disable iff (reset) o_trace_a.wen |-> o_trace_a.wnum != '0
    ) else $error("lane a traced a write to x0");

    a_trace_b_no_x0: assert property (
        @(posedge clk) disable iff (reset) o_trace_b.wen |-> o_trace_b.wnum != '0
    ) else $error("lane b traced a write to x0");

endmodule

// ==== dual_issue_core.sv ====
`timescale 1ns/1ps

module dual_issue_core (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      i_issue,
    input  dual_issue_pkg::issue_op_t i_issue_a,
    input  dual_issue_pkg::issue_op_t i_issue_b,
    output dual_issue_pkg::trace_t    o_trace_a,
    output dual_issue_pkg::trace_t    o_trace_b
);
    import dual_issue_pkg::*;

    exec_op_t        exec_a;
    exec_op_t        exec_b;
    result_t         ex_result_a;
    result_t         ex_result_b;
    result_t         wb_result_a;
    result_t         wb_result_b;
    reg_addr_t [3:0] rf_raddr;
    word_t     [3:0] rf_rdata;

    operand_read u_operand_read (
        .clk           (clk),
        .reset         (reset),
        .i_issue       (i_issue),
        .i_issue_a     (i_issue_a),
        .i_issue_b     (i_issue_b),
        .i_ex_result_a (ex_result_a),
        .i_ex_result_b (ex_result_b),
        .i_wb_result_a (wb_result_a),
        .i_wb_result_b (wb_result_b),
        .o_raddr       (rf_raddr),
        .i_rdata       (rf_rdata),
        .o_exec_a      (exec_a),
        .o_exec_b      (exec_b)
    );

    alu_execute u_alu_execute (
        .clk        (clk),
        .reset      (reset),
        .i_exec_a   (exec_a),
        .i_exec_b   (exec_b),
        .o_result_a (ex_result_a),
        .o_result_b (ex_result_b)
    );

    writeback u_writeback (
        .clk           (clk),
        .reset         (reset),
        .i_result_a    (ex_result_a),
        .i_result_b    (ex_result_b),
        .o_wb_result_a (wb_result_a),
        .o_wb_result_b (wb_result_b),
        .o_trace_a     (o_trace_a),
        .o_trace_b     (o_trace_b)
    );

    regfile u_regfile (
        .clk     (clk),
        .reset   (reset),
        .i_raddr (rf_raddr),
        .o_rdata (rf_rdata),
        .i_wr_a  (wb_result_a),
        .i_wr_b  (wb_result_b)
    );

endmodule

// ==== tb_dual_issue_core.sv ====
`timescale 1ns/1ps

`include "dual_issue_cfg.svh"

module tb_dual_issue_core;
    import dual_issue_pkg::*;

    localparam int DIRECTED_CYCLES = 57;
    localparam int RANDOM_CYCLES   = 200;
    localparam int LATENCY         = 4;

    logic      clk;
    logic      reset;
    logic      i_issue;
    issue_op_t i_issue_a;
    issue_op_t i_issue_b;
    trace_t    o_trace_a;
    trace_t    o_trace_b;

    word_t       ref_regs [`DI_REG_COUNT];
    trace_t      exp_q_a [$];
    trace_t      exp_q_b [$];
    logic [31:0] next_pc;
    logic [31:0] lcg_state;

    dual_issue_core uut (
        .clk       (clk),
        .reset     (reset),
        .i_issue   (i_issue),
        .i_issue_a (i_issue_a),
        .i_issue_b (i_issue_b),
        .o_trace_a (o_trace_a),
        .o_trace_b (o_trace_b)
    );

    always #4 clk = ~clk;

    initial begin
        #((DIRECTED_CYCLES + RANDOM_CYCLES + 50) * 8);
        $display("Watchdog expired before the tests finished.");
        $display("Test failed");
        $fatal(1, "simulation timed out");
    end

    // ##########################################################################
    // Reference model.
    // ##########################################################################

    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic word_t model_alu(input alu_op_t op, input word_t a, input word_t b);
        word_t      res;
        logic [4:0] sh;
        sh = b[4:0];
        case (op)
            ALU_ADD:  res = a + b;
            ALU_SUB:  res = a + ~b + 32'd1;
            ALU_AND:  res = a & b;
            ALU_OR:   res = a | b;
            ALU_XOR:  res = a ^ b;
            ALU_SLL:  res = a << sh;
            ALU_SRL:  res = a >> sh;
            ALU_SRA: begin
                res = a >> sh;
                if (a[31]) begin
                    res = res | ~(32'hffff_ffff >> sh);
                end
            end
            ALU_SLT:  res = {31'd0, (a ^ 32'h8000_0000) < (b ^ 32'h8000_0000)};
            ALU_SLTU: res = {31'd0, a < b};
            ALU_LUI:  res = b;
            default:  res = 32'hdead_beef;
        endcase
        return res;
    endfunction

    // Retires one lane into the model and returns its expected trace.
    function automatic trace_t retire_model(input logic issue, input issue_op_t o);
        trace_t t;
        word_t  opnd2;
        t = '0;
        opnd2 = o.src2_is_imm ? o.imm : ref_regs[o.src2];
        if (issue && o.valid && o.dest != '0) begin
            t.wen   = 1'b1;
            t.pc    = o.pc;
            t.wnum  = o.dest;
            t.wdata = model_alu(o.op, ref_regs[o.src1], opnd2);
            ref_regs[o.dest] = t.wdata;
        end
        return t;
    endfunction

    function automatic issue_op_t make_op(input alu_op_t op, input reg_addr_t src1,
                                          input reg_addr_t src2, input logic is_imm,
                                          input word_t imm, input reg_addr_t dest);
        issue_op_t o;
        o.valid       = 1'b1;
        o.pc          = next_pc;
        o.op          = op;
        o.src1        = src1;
        o.src2        = src2;
        o.src2_is_imm = is_imm;
        o.imm         = imm;
        o.dest        = dest;
        next_pc = next_pc + 32'd4;
        return o;
    endfunction

    function automatic issue_op_t op_imm(input alu_op_t op, input reg_addr_t src1,
                                         input word_t imm, input reg_addr_t dest);
        return make_op(op, src1, 5'd0, 1'b1, imm, dest);
    endfunction

    function automatic issue_op_t op_reg(input alu_op_t op, input reg_addr_t src1,
                                         input reg_addr_t src2, input reg_addr_t dest);
        return make_op(op, src1, src2, 1'b0, 32'd0, dest);
    endfunction

    function automatic issue_op_t bubble();
        return '0;
    endfunction

    // ##########################################################################
    // Drive and check.
    // ##########################################################################

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("[FAIL] t=%0t %s expected %h got %h", $time, name, expected, actual);
            $display("Test failed");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    task automatic check_lane(input string name, input trace_t expected, input trace_t actual);
        check_value({name, ".wen"}, 32'(expected.wen), 32'(actual.wen));
        if (expected.wen) begin
            check_value({name, ".pc"}, expected.pc, actual.pc);
            check_value({name, ".wnum"}, 32'(expected.wnum), 32'(actual.wnum));
            check_value({name, ".wdata"}, expected.wdata, actual.wdata);
        end
    endtask

    // Entry pushed LATENCY ticks ago belongs to the trace now on the outputs.
    task automatic compare_traces();
        if (exp_q_a.size() == LATENCY) begin
            check_lane("o_trace_a", exp_q_a.pop_front(), o_trace_a);
            check_lane("o_trace_b", exp_q_b.pop_front(), o_trace_b);
        end
    endtask

    task automatic drive_cycle(input logic issue, input issue_op_t a, input issue_op_t b);
        exp_q_a.push_back(retire_model(issue, a));
        exp_q_b.push_back(retire_model(issue, b));
        i_issue   = issue;
        i_issue_a = a;
        i_issue_b = b;
        @(posedge clk);
        #1;
        compare_traces();
    endtask

    task automatic issue_pair(input issue_op_t a, input issue_op_t b);
        drive_cycle(1'b1, a, b);
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) drive_cycle(1'b0, bubble(), bubble());
    endtask

    // ##########################################################################
    // Tests.
    // ##########################################################################

    task automatic test_reset_idle();
        idle_cycles(5);
        issue_pair(op_imm(ALU_ADD, 5'd0, 32'd0, 5'd1), bubble());
    endtask

    task automatic test_alu_ops();
        alu_op_t op;
        issue_pair(op_imm(ALU_LUI, 5'd0, 32'h8000_1234, 5'd1),
                   op_imm(ALU_LUI, 5'd0, 32'hffff_ffe5, 5'd4));
        issue_pair(op_imm(ALU_ADD, 5'd0, 32'h0f0f_00f3, 5'd3), bubble());
        for (int k = 0; k < 11; k++) begin
            op = alu_op_t'(4'(k));
            issue_pair(op_imm(op, 5'd1, 32'd7, 5'd10), op_reg(op, 5'd4, 5'd3, 5'd11));
        end
    endtask

    task automatic test_forwarding();
        issue_pair(op_imm(ALU_ADD, 5'd0, 32'd100, 5'd12),
                   op_imm(ALU_XOR, 5'd0, 32'h55, 5'd13));
        issue_pair(op_reg(ALU_ADD, 5'd12, 5'd13, 5'd14),
                   op_imm(ALU_ADD, 5'd12, 32'd1, 5'd15));
        issue_pair(op_reg(ALU_SUB, 5'd14, 5'd12, 5'd16),
                   op_reg(ALU_OR, 5'd15, 5'd13, 5'd17));
        idle_cycles(1);
        issue_pair(op_reg(ALU_ADD, 5'd16, 5'd14, 5'd18),
                   op_reg(ALU_AND, 5'd17, 5'd12, 5'd19));
        idle_cycles(2);
        issue_pair(op_reg(ALU_ADD, 5'd18, 5'd19, 5'd20),
                   op_reg(ALU_ADD, 5'd16, 5'd17, 5'd21));
        idle_cycles(3);
        issue_pair(op_reg(ALU_XOR, 5'd20, 5'd21, 5'd22),
                   op_imm(ALU_SLL, 5'd21, 32'd3, 5'd23));
        // Back to back chain, lane b feeds lane a of the next pair.
        repeat (6) begin
            issue_pair(op_reg(ALU_ADD, 5'd24, 5'd25, 5'd24),
                       op_imm(ALU_ADD, 5'd25, 32'd3, 5'd25));
        end
    endtask

    task automatic test_same_dest();
        issue_pair(op_imm(ALU_ADD, 5'd0, 32'd11, 5'd26),
                   op_imm(ALU_ADD, 5'd0, 32'd22, 5'd26));
        issue_pair(op_imm(ALU_ADD, 5'd26, 32'd0, 5'd27),
                   op_imm(ALU_ADD, 5'd26, 32'd1, 5'd30));
        issue_pair(op_imm(ALU_ADD, 5'd26, 32'd0, 5'd28), bubble());
        idle_cycles(4);
        issue_pair(op_imm(ALU_ADD, 5'd26, 32'd0, 5'd29), bubble());
    endtask

    task automatic test_x0_write();
        issue_pair(op_imm(ALU_ADD, 5'd0, 32'h123, 5'd0),
                   op_imm(ALU_ADD, 5'd0, 32'd5, 5'd31));
        issue_pair(op_reg(ALU_OR, 5'd0, 5'd0, 5'd1),
                   op_imm(ALU_ADD, 5'd0, 32'd0, 5'd2));
        idle_cycles(3);
        issue_pair(op_reg(ALU_ADD, 5'd0, 5'd0, 5'd3), bubble());
    endtask

    function automatic issue_op_t random_op();
        logic [31:0] r;
        issue_op_t   o;
        r = next_random();
        o = make_op(alu_op_t'(4'(r[31:24] % 8'd11)), r[8:4], r[13:9], r[19],
                    next_random(), r[18:14]);
        o.valid = (r[22:20] != 3'd0);
        return o;
    endfunction

    task automatic test_random();
        issue_op_t a;
        issue_op_t b;
        logic      go;
        for (int n = 0; n < RANDOM_CYCLES; n++) begin
            go = (next_random() & 32'h3) != 32'd0;
            a = random_op();
            b = random_op();
            // Lane b may not read lane a's destination in the same pair.
            if (a.valid && a.dest != '0) begin
                if (b.src1 == a.dest) b.src1 = '0;
                if (b.src2 == a.dest) b.src2 = '0;
            end
            drive_cycle(go, a, b);
        end
    endtask

    initial begin
        clk       = 1'b0;
        reset     = 1'b1;
        i_issue   = 1'b0;
        i_issue_a = '0;
        i_issue_b = '0;
        next_pc   = 32'h0000_1000;
        lcg_state = 32'h9935154f;
        for (int i = 0; i < `DI_REG_COUNT; i++) begin
            ref_regs[i] = '0;
        end
        repeat (2) @(posedge clk);
        #1;
        reset = 1'b0;
        // Stages cleared by reset drain as bubbles.
        repeat (LATENCY - 1) begin
            exp_q_a.push_back('0);
            exp_q_b.push_back('0);
        end

        test_reset_idle();
        test_alu_ops();
        test_forwarding();
        test_same_dest();
        test_x0_write();
        test_random();
        idle_cycles(LATENCY);

        $display("Test completed successfully");
        $finish;
    end

endmodule

// ==== dual_issue_core.f ====
+incdir+.
dual_issue_pkg.sv
regfile.sv
operand_read.sv
alu_execute.sv
writeback.sv
dual_issue_core.sv
tb_dual_issue_core.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" &&
    verilator --binary --timing --assert -j 0 --top-module tb_dual_issue_core \
        -f dual_issue_core.f -o sim_dual_issue_core &&
    ./obj_dir/sim_dual_issue_core ||
    { echo "dual_issue_core simulation failed"; exit 1; }
